// ==== logic/vtp_config.svh ====
`ifndef VTP_CONFIG_SVH
`define VTP_CONFIG_SVH

// Number of translation ports, each with its own L1
`define VTP_N_PORTS 4

// Virtual page number width, which also sizes the on-chip page table
`define VTP_VPN_BITS 6

// Physical page number width
`define VTP_PPN_BITS 10

// Byte offset within a page
`define VTP_OFFSET_BITS 12

// Direct-mapped L1 entries per port, indexed by the low page number bits
`define VTP_L1_ENTRIES 4

`endif

// ==== logic/vtp_types_pkg.sv ====
`default_nettype none

`include "vtp_config.svh"

package vtp_types_pkg;

    // Page numbers and offsets as they appear on the translation ports
    typedef logic [`VTP_VPN_BITS-1:0] vpn_t;
    typedef logic [`VTP_PPN_BITS-1:0] ppn_t;
    typedef logic [`VTP_OFFSET_BITS-1:0] offset_t;

    // Per-port L1 sequencing
    typedef enum logic [1:0]
    {
        l1_idle,
        l1_miss_wait,
        l1_respond
    } l1_state_t;

    // Shared L2 miss service sequencing
    typedef enum logic [1:0]
    {
        l2_idle,
        l2_lookup,
        l2_reply
    } l2_state_t;

endpackage

`default_nettype wire

// ==== logic/vtp_csr_pkg.sv ====
`default_nettype none

package vtp_csr_pkg;

    // Register targeted by the current APB address
    typedef enum logic [2:0]
    {
        reg_ctrl,
        reg_hit_count,
        reg_miss_count,
        reg_pte,
        reg_none
    } csr_reg_t;

    // Byte addresses of the register map
    localparam logic [11:0] addr_ctrl = 12'h000;
    localparam logic [11:0] addr_hit_count = 12'h004;
    localparam logic [11:0] addr_miss_count = 12'h008;
    localparam logic [11:0] pte_base = 12'h100;

    // Bit positions inside the ctrl register and inside a page table entry word
    localparam int ctrl_enable_bit = 0;
    localparam int pte_valid_bit = 16;
    localparam int pte_ppn_lsb = 0;

endpackage

`default_nettype wire

// ==== logic/vtp_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vtp_config.svh"

module vtp_csr
    import vtp_types_pkg::*, vtp_csr_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic [11:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,

    input  logic [`VTP_N_PORTS-1:0] hit,
    input  logic [`VTP_N_PORTS-1:0] miss,
    output logic enable,
    output logic flush,

    output logic pte_we,
    output vpn_t pte_vpn,
    output logic [31:0] pte_word
);

    csr_reg_t reg_sel;
    logic access;
    logic bad_access;
    logic [31:0] hit_count;
    logic [31:0] miss_count;

    // Number of ports that raised a pulse this cycle
    function automatic logic [31:0] count_pulses(input logic [`VTP_N_PORTS-1:0] pulses);
        logic [31:0] total;
        total = '0;
        for (int i = 0; i < `VTP_N_PORTS; i++)
        begin
            total = total + 32'(pulses[i]);
        end
        return total;
    endfunction

    // Counters stick at all ones instead of wrapping
    function automatic logic [31:0] sat_add(input logic [31:0] base, input logic [31:0] incr);
        logic [32:0] sum;
        sum = {1'b0, base} + {1'b0, incr};
        return sum[32] ? '1 : sum[31:0];
    endfunction

    // The whole 0x100 page is the page table window, one word per page number
    always_comb
    begin
        if (paddr[11:8] == pte_base[11:8])
        begin
            reg_sel = reg_pte;
        end
        else
        begin
            case (paddr)
                addr_ctrl:       reg_sel = reg_ctrl;
                addr_hit_count:  reg_sel = reg_hit_count;
                addr_miss_count: reg_sel = reg_miss_count;
                default:         reg_sel = reg_none;
            endcase
        end
    end

    assign access = psel && penable;

    // Unmapped addresses, counter writes and table reads are all rejected
    assign bad_access = (reg_sel == reg_none) ||
                        (pwrite && ((reg_sel == reg_hit_count) || (reg_sel == reg_miss_count))) ||
                        (!pwrite && (reg_sel == reg_pte));

    // No wait states, so the access completes in its first access cycle
    assign pready = 1'b1;
    assign pslverr = access && bad_access;

    always_comb
    begin
        case (reg_sel)
            reg_ctrl:       prdata = 32'(enable) << ctrl_enable_bit;
            reg_hit_count:  prdata = hit_count;
            reg_miss_count: prdata = miss_count;
            default:        prdata = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enable <= 1'b0;
            flush <= 1'b0;
            pte_we <= 1'b0;
            hit_count <= '0;
            miss_count <= '0;
        end
        else
        begin
            // Every port can report in the same cycle
            hit_count <= sat_add(hit_count, count_pulses(hit));
            miss_count <= sat_add(miss_count, count_pulses(miss));

            if (access && pwrite && !bad_access && (reg_sel == reg_ctrl))
            begin
                enable <= pwdata[ctrl_enable_bit];
            end

            // A table update must invalidate every L1 copy of the old entry
            pte_we <= access && pwrite && !bad_access && (reg_sel == reg_pte);
            flush <= access && pwrite && !bad_access && (reg_sel == reg_pte);
        end
    end

    // Entry payload for the L2 travels alongside pte_we
    always_ff @(posedge clk)
    begin
        if (access && pwrite && (reg_sel == reg_pte))
        begin
            pte_vpn <= vpn_t'(paddr[2 +: `VTP_VPN_BITS]);
            pte_word <= pwdata;
        end
    end

    // The access phase is only legal as the continuation of a selected transfer
    apb_enable_needs_select: assert property (
        @(posedge clk) disable iff (reset)
        penable |-> psel
    ) else $error("penable high without psel");

endmodule

`default_nettype wire

// ==== logic/vtp_l1_tlb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vtp_config.svh"

module vtp_l1_tlb
    import vtp_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic enable,
    input  logic flush,

    input  logic req_valid,
    input  logic [`VTP_VPN_BITS+`VTP_OFFSET_BITS-1:0] req_va,
    output logic req_ready,

    output logic rsp_valid,
    output logic [`VTP_PPN_BITS+`VTP_OFFSET_BITS-1:0] rsp_pa,
    output logic rsp_fault,
    input  logic rsp_ready,

    output logic miss_req,
    output vpn_t miss_vpn,
    input  logic miss_gnt,

    input  logic fill_valid,
    input  ppn_t fill_ppn,
    input  logic fill_fault,

    output logic hit,
    output logic miss
);

    localparam int va_bits = `VTP_VPN_BITS + `VTP_OFFSET_BITS;
    localparam int pa_bits = `VTP_PPN_BITS + `VTP_OFFSET_BITS;
    localparam int idx_bits = $clog2(`VTP_L1_ENTRIES);
    localparam int tag_bits = `VTP_VPN_BITS - idx_bits;

    l1_state_t state;

    logic [`VTP_L1_ENTRIES-1:0] entry_valid;
    logic [tag_bits-1:0] entry_tag [`VTP_L1_ENTRIES];
    ppn_t entry_ppn [`VTP_L1_ENTRIES];

    vpn_t req_vpn;
    offset_t req_offset;
    logic [idx_bits-1:0] req_idx;
    logic [idx_bits-1:0] miss_idx;
    offset_t pend_offset;

    logic accept;
    logic lookup_hit;
    logic fill_stale;
    logic do_install;

    assign req_vpn = req_va[va_bits-1:`VTP_OFFSET_BITS];
    assign req_offset = req_va[`VTP_OFFSET_BITS-1:0];
    assign req_idx = req_vpn[idx_bits-1:0];
    assign miss_idx = miss_vpn[idx_bits-1:0];

    // req_ready is only high in idle, so an accepted request always starts there
    assign accept = req_valid && req_ready;

    // A flush in the same cycle wins over a hit on the old contents
    assign lookup_hit = entry_valid[req_idx] &&
                        (entry_tag[req_idx] == req_vpn[`VTP_VPN_BITS-1:idx_bits]) &&
                        !flush;

    // Faults are never cached, and a fill that raced with a flush may be stale
    assign do_install = (state == l1_miss_wait) && fill_valid && !fill_fault &&
                        !fill_stale && !flush;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= l1_idle;
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            miss_req <= 1'b0;
            fill_stale <= 1'b0;
            entry_valid <= '0;
            hit <= 1'b0;
            miss <= 1'b0;
        end
        else
        begin
            hit <= 1'b0;
            miss <= 1'b0;

            case (state)
                l1_idle:
                begin
                    if (accept)
                    begin
                        req_ready <= 1'b0;
                        if (enable && !lookup_hit)
                        begin
                            miss <= 1'b1;
                            miss_req <= 1'b1;
                            fill_stale <= 1'b0;
                            state <= l1_miss_wait;
                        end
                        else
                        begin
                            // Identity translation with the service disabled is not counted
                            hit <= enable;
                            rsp_valid <= 1'b1;
                            state <= l1_respond;
                        end
                    end
                    else
                    begin
                        req_ready <= 1'b1;
                    end
                end

                l1_miss_wait:
                begin
                    // The request stays up until the L2 picks this port
                    if (miss_gnt)
                    begin
                        miss_req <= 1'b0;
                    end
                    if (flush)
                    begin
                        fill_stale <= 1'b1;
                    end
                    if (fill_valid)
                    begin
                        rsp_valid <= 1'b1;
                        state <= l1_respond;
                    end
                end

                l1_respond:
                begin
                    if (rsp_ready)
                    begin
                        rsp_valid <= 1'b0;
                        req_ready <= 1'b1;
                        state <= l1_idle;
                    end
                end

                default:
                begin
                    state <= l1_idle;
                end
            endcase

            if (flush)
            begin
                entry_valid <= '0;
            end
            else if (do_install)
            begin
                entry_valid[miss_idx] <= 1'b1;
            end
        end
    end

    // Response payload and cache contents
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            miss_vpn <= req_vpn;
            pend_offset <= req_offset;
            rsp_fault <= 1'b0;
            if (!enable)
            begin
                rsp_pa <= {{(pa_bits - va_bits){1'b0}}, req_va};
            end
            else
            begin
                // On a miss this is overwritten when the fill arrives
                rsp_pa <= {entry_ppn[req_idx], req_offset};
            end
        end
        else if ((state == l1_miss_wait) && fill_valid)
        begin
            rsp_pa <= fill_fault ? '0 : {fill_ppn, pend_offset};
            rsp_fault <= fill_fault;
        end

        if (do_install)
        begin
            entry_tag[miss_idx] <= miss_vpn[`VTP_VPN_BITS-1:idx_bits];
            entry_ppn[miss_idx] <= fill_ppn;
        end
    end

    // Consumer may stall, and the response must then hold still
    rsp_stable_until_accepted: assert property (
        @(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_pa) && $stable(rsp_fault)
    ) else $error("response changed before it was accepted");

endmodule

`default_nettype wire

// ==== logic/vtp_l2_service.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vtp_config.svh"

module vtp_l2_service
    import vtp_types_pkg::*, vtp_csr_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic pte_we,
    input  vpn_t pte_vpn,
    input  logic [31:0] pte_word,

    input  logic [`VTP_N_PORTS-1:0] miss_req,
    input  vpn_t miss_vpn [`VTP_N_PORTS],
    output logic [`VTP_N_PORTS-1:0] miss_gnt,

    output logic [`VTP_N_PORTS-1:0] fill_valid,
    output ppn_t fill_ppn,
    output logic fill_fault
);

    localparam int port_bits = $clog2(`VTP_N_PORTS);
    localparam int table_size = 1 << `VTP_VPN_BITS;

    l2_state_t state;

    logic [table_size-1:0] pt_valid;
    ppn_t pt_ppn [table_size];

    logic [port_bits-1:0] rr_ptr;
    logic [port_bits-1:0] sel_port;
    logic sel_found;
    logic [port_bits-1:0] cur_port;
    vpn_t cur_vpn;

    // Search for a requester starting at the port after the last one served
    always_comb
    begin
        sel_found = 1'b0;
        sel_port = rr_ptr;
        for (int i = 0; i < `VTP_N_PORTS; i++)
        begin
            if (!sel_found && miss_req[(int'(rr_ptr) + i) % `VTP_N_PORTS])
            begin
                sel_found = 1'b1;
                sel_port = port_bits'((int'(rr_ptr) + i) % `VTP_N_PORTS);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= l2_idle;
            rr_ptr <= '0;
            miss_gnt <= '0;
            fill_valid <= '0;
            pt_valid <= '0;
            for (int v = 0; v < table_size; v++)
            begin
                pt_ppn[v] <= '0;
            end
        end
        else
        begin
            // Grant and fill are single-cycle pulses
            miss_gnt <= '0;
            fill_valid <= '0;

            case (state)
                l2_idle:
                begin
                    if (sel_found)
                    begin
                        miss_gnt[sel_port] <= 1'b1;
                        rr_ptr <= port_bits'((int'(sel_port) + 1) % `VTP_N_PORTS);
                        state <= l2_lookup;
                    end
                end

                l2_lookup:
                begin
                    fill_valid[cur_port] <= 1'b1;
                    state <= l2_reply;
                end

                l2_reply:
                begin
                    state <= l2_idle;
                end

                default:
                begin
                    state <= l2_idle;
                end
            endcase

            // Software updates the table at any time
            if (pte_we)
            begin
                pt_valid[pte_vpn] <= pte_word[pte_valid_bit];
                pt_ppn[pte_vpn] <= pte_word[pte_ppn_lsb +: `VTP_PPN_BITS];
            end
        end
    end

    // Miss being served and the result of the table read
    always_ff @(posedge clk)
    begin
        if ((state == l2_idle) && sel_found)
        begin
            cur_port <= sel_port;
            cur_vpn <= miss_vpn[sel_port];
        end

        if (state == l2_lookup)
        begin
            fill_ppn <= pt_ppn[cur_vpn];
            fill_fault <= !pt_valid[cur_vpn];
        end
    end

    // A grant goes to a single port, and only to one that still holds its request
    gnt_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(miss_gnt) && ((miss_gnt & ~miss_req) == '0)
    ) else $error("grant to more than one port or to a port without a request");

    // The fill answers the port that was granted in the cycle before
    fill_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(fill_valid) && ((fill_valid == '0) || (fill_valid == $past(miss_gnt)))
    ) else $error("fill sent to more than one port or to a port that was not granted");

endmodule

`default_nettype wire

// ==== logic/vtp_svc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vtp_config.svh"

module vtp_svc
    import vtp_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  logic [11:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,

    input  logic [`VTP_N_PORTS-1:0] req_valid,
    input  logic [`VTP_VPN_BITS+`VTP_OFFSET_BITS-1:0] req_va [`VTP_N_PORTS],
    output logic [`VTP_N_PORTS-1:0] req_ready,
    output logic [`VTP_N_PORTS-1:0] rsp_valid,
    output logic [`VTP_PPN_BITS+`VTP_OFFSET_BITS-1:0] rsp_pa [`VTP_N_PORTS],
    output logic [`VTP_N_PORTS-1:0] rsp_fault,
    input  logic [`VTP_N_PORTS-1:0] rsp_ready
);

    // Sideband from the register block to the caches
    logic enable;
    logic flush;
    logic [`VTP_N_PORTS-1:0] hit;
    logic [`VTP_N_PORTS-1:0] miss;

    // Table update path into the L2
    logic pte_we;
    vpn_t pte_vpn;
    logic [31:0] pte_word;

    // Miss traffic between the L1s and the shared service
    logic [`VTP_N_PORTS-1:0] miss_req;
    vpn_t miss_vpn [`VTP_N_PORTS];
    logic [`VTP_N_PORTS-1:0] miss_gnt;
    logic [`VTP_N_PORTS-1:0] fill_valid;
    ppn_t fill_ppn;
    logic fill_fault;

    vtp_csr csr_mgr
    (
        .clk,
        .reset,
        .paddr,
        .psel,
        .penable,
        .pwrite,
        .pwdata,
        .prdata,
        .pready,
        .pslverr,
        .hit,
        .miss,
        .enable,
        .flush,
        .pte_we,
        .pte_vpn,
        .pte_word
    );

    // One private cache per port, all fed by the same fill bus
    for (genvar p = 0; p < `VTP_N_PORTS; p++)
    begin : l1
        vtp_l1_tlb tlb
        (
            .clk,
            .reset,
            .enable,
            .flush,
            .req_valid(req_valid[p]),
            .req_va(req_va[p]),
            .req_ready(req_ready[p]),
            .rsp_valid(rsp_valid[p]),
            .rsp_pa(rsp_pa[p]),
            .rsp_fault(rsp_fault[p]),
            .rsp_ready(rsp_ready[p]),
            .miss_req(miss_req[p]),
            .miss_vpn(miss_vpn[p]),
            .miss_gnt(miss_gnt[p]),
            .fill_valid(fill_valid[p]),
            .fill_ppn,
            .fill_fault,
            .hit(hit[p]),
            .miss(miss[p])
        );
    end

    vtp_l2_service l2
    (
        .clk,
        .reset,
        .pte_we,
        .pte_vpn,
        .pte_word,
        .miss_req,
        .miss_vpn,
        .miss_gnt,
        .fill_valid,
        .fill_ppn,
        .fill_fault
    );

endmodule

`default_nettype wire

// ==== dv/vtp_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module vtp_clk_gen
(
    output logic clk,
    output logic reset
);

    // 4 ns period, so each half period is 2 ns
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    // Reset spans 8 rising edges and drops on a falling edge, like every other input
    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/vtp_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vtp_config.svh"

module vtp_tb;

    localparam int n_ports = `VTP_N_PORTS;
    localparam int va_bits = `VTP_VPN_BITS + `VTP_OFFSET_BITS;
    localparam int pa_bits = `VTP_PPN_BITS + `VTP_OFFSET_BITS;
    localparam int offset_bits = `VTP_OFFSET_BITS;
    localparam int table_size = 1 << `VTP_VPN_BITS;
    localparam int wait_limit = 100;
    localparam int max_rows = 64;

    typedef enum int
    {
        apb_write,
        apb_read,
        xlate
    } step_kind_t;

    logic clk;
    logic reset;

    logic [11:0] paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    logic [n_ports-1:0] req_valid;
    logic [va_bits-1:0] req_va [n_ports];
    logic [n_ports-1:0] req_ready;
    logic [n_ports-1:0] rsp_valid;
    logic [pa_bits-1:0] rsp_pa [n_ports];
    logic [n_ports-1:0] rsp_fault;
    logic [n_ports-1:0] rsp_ready;

    integer seed;

    // Reference page table and enable bit follow the APB writes that succeed
    logic pt_valid [table_size];
    logic [`VTP_PPN_BITS-1:0] pt_ppn [table_size];
    logic model_enable;

    // Stimulus table with one step per row
    step_kind_t row_kind [max_rows];
    int row_port [max_rows];
    logic [31:0] row_addr [max_rows];
    logic [31:0] row_data [max_rows];
    logic [31:0] row_exp [max_rows];
    logic row_err [max_rows];
    int n_rows;

    logic [31:0] reg_value;

    vtp_clk_gen clk_rst
    (
        .clk(clk),
        .reset(reset)
    );

    vtp_svc i_vtp_svc
    (
        .clk(clk),
        .reset(reset),
        .paddr(paddr),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .req_valid(req_valid),
        .req_va(req_va),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp_pa(rsp_pa),
        .rsp_fault(rsp_fault),
        .rsp_ready(rsp_ready)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic wait_expired(input string what);
        $display("Gave up after %0d cycles waiting for %s", wait_limit, what);
        $display("sim failed");
        $fatal(1);
    endtask

    // Translation as the register map defines it, independent of any cache state
    function automatic logic [pa_bits-1:0] expected_pa(input logic [va_bits-1:0] va);
        int vpn;
        vpn = int'(va[va_bits-1:offset_bits]);
        if (!model_enable)
        begin
            return pa_bits'(va);
        end
        if (!pt_valid[vpn])
        begin
            return '0;
        end
        return {pt_ppn[vpn], va[offset_bits-1:0]};
    endfunction

    function automatic logic expected_fault(input logic [va_bits-1:0] va);
        return model_enable && !pt_valid[int'(va[va_bits-1:offset_bits])];
    endfunction

    // Runs one APB transfer as a setup phase and then an access phase from a falling edge
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        paddr = addr;
        pwrite = write;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // Read data and error are combinational, so look halfway into the access cycle
        #1;
        rdata = prdata;
        err = pslverr;
        check_value("pready", 32'(pready), 32'h1);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic write_checked(input logic [11:0] addr, input logic [31:0] data,
                                 input logic exp_err);
        logic [31:0] rdata;
        logic err;
        int vpn;
        apb_access(1'b1, addr, data, rdata, err);
        check_value($sformatf("pslverr (write 0x%0h)", addr), 32'(err), 32'(exp_err));
        if (!exp_err && (addr == 12'h000))
        begin
            model_enable = data[0];
        end
        // Table words start at 0x100, one word per page number
        if (!exp_err && (addr[11:8] == 4'h1))
        begin
            vpn = int'(addr[7:2]);
            pt_valid[vpn] = data[16];
            pt_ppn[vpn] = data[`VTP_PPN_BITS-1:0];
        end
    endtask

    task automatic read_checked(input logic [11:0] addr, input logic [31:0] exp_data,
                                input logic exp_err);
        logic [31:0] rdata;
        logic err;
        apb_access(1'b0, addr, 32'h0, rdata, err);
        check_value($sformatf("pslverr (read 0x%0h)", addr), 32'(err), 32'(exp_err));
        // Read data carries no meaning on a rejected access
        if (!exp_err)
        begin
            check_value($sformatf("prdata (read 0x%0h)", addr), rdata, exp_data);
        end
    endtask

    task automatic read_reg(input logic [11:0] addr, output logic [31:0] value);
        logic err;
        apb_access(1'b0, addr, 32'h0, value, err);
        check_value($sformatf("pslverr (read 0x%0h)", addr), 32'(err), 32'h0);
    endtask

    // Issue one translation on port p and check the response against the model
    task automatic run_translation(input int p, input logic [va_bits-1:0] va);
        logic [pa_bits-1:0] pa;
        logic fault;
        int hold;
        int cycles;
        req_va[p] = va;
        req_valid[p] = 1'b1;
        cycles = 0;
        // req_ready only moves on rising edges, so its value now decides the next edge
        while (!req_ready[p])
        begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit)
            begin
                wait_expired($sformatf("port %0d to accept a request", p));
            end
        end
        @(negedge clk);
        req_valid[p] = 1'b0;
        cycles = 0;
        while (!rsp_valid[p])
        begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit)
            begin
                wait_expired($sformatf("a response on port %0d", p));
            end
        end
        pa = rsp_pa[p];
        fault = rsp_fault[p];
        check_value($sformatf("rsp_pa[%0d]", p), 32'(pa), 32'(expected_pa(va)));
        check_value($sformatf("rsp_fault[%0d]", p), 32'(fault), 32'(expected_fault(va)));
        // Stall the consumer a little and watch that the response holds still
        hold = $unsigned($random(seed)) % 4;
        repeat (hold)
        begin
            @(negedge clk);
            check_value($sformatf("rsp_valid[%0d]", p), 32'(rsp_valid[p]), 32'h1);
            check_value($sformatf("rsp_pa[%0d]", p), 32'(rsp_pa[p]), 32'(pa));
            check_value($sformatf("rsp_fault[%0d]", p), 32'(rsp_fault[p]), 32'(fault));
        end
        rsp_ready[p] = 1'b1;
        @(negedge clk);
        rsp_ready[p] = 1'b0;
    endtask

    task automatic add_row(input step_kind_t kind, input int port, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] exp,
                           input logic err);
        row_kind[n_rows] = kind;
        row_port[n_rows] = port;
        row_addr[n_rows] = addr;
        row_data[n_rows] = data;
        row_exp[n_rows] = exp;
        row_err[n_rows] = err;
        n_rows++;
    endtask

    // Translation rows take their expected pa and fault from the model instead
    task automatic build_table();
        n_rows = 0;
        // The service is disabled after reset, so every port echoes its va
        add_row(apb_read, 0, 32'h000, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 0, 32'h25123, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 1, 32'h3FFFF, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 2, 32'h00000, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 3, 32'h1A5A5, 32'h0, 32'h0, 1'b0);
        add_row(apb_read, 0, 32'h004, 32'h0, 32'h0, 1'b0);
        add_row(apb_read, 0, 32'h008, 32'h0, 32'h0, 1'b0);
        // Write two valid pages and one invalid one and then turn translation on
        add_row(apb_write, 0, 32'h114, 32'h0001_03A7, 32'h0, 1'b0);
        add_row(apb_write, 0, 32'h118, 32'h0001_0155, 32'h0, 1'b0);
        add_row(apb_write, 0, 32'h1A8, 32'h0000_0123, 32'h0, 1'b0);
        add_row(apb_write, 0, 32'h000, 32'h1, 32'h0, 1'b0);
        // Miss then hit on two different L1 slots of port 0
        add_row(xlate, 0, 32'h050AB, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 0, 32'h05FFF, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 0, 32'h06010, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 0, 32'h06020, 32'h0, 32'h0, 1'b0);
        add_row(apb_read, 0, 32'h004, 32'h0, 32'h2, 1'b0);
        add_row(apb_read, 0, 32'h008, 32'h0, 32'h2, 1'b0);
        // An invalid page faults every time and is never cached
        add_row(xlate, 1, 32'h2A777, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 1, 32'h2A001, 32'h0, 32'h0, 1'b0);
        add_row(apb_read, 0, 32'h004, 32'h0, 32'h2, 1'b0);
        add_row(apb_read, 0, 32'h008, 32'h0, 32'h4, 1'b0);
        // Remapping page 5 flushes every L1, so page 6 misses again too
        add_row(apb_write, 0, 32'h114, 32'h0001_0222, 32'h0, 1'b0);
        add_row(xlate, 0, 32'h05123, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 0, 32'h05124, 32'h0, 32'h0, 1'b0);
        add_row(xlate, 0, 32'h06030, 32'h0, 32'h0, 1'b0);
        add_row(apb_read, 0, 32'h004, 32'h0, 32'h3, 1'b0);
        add_row(apb_read, 0, 32'h008, 32'h0, 32'h6, 1'b0);
        // Rejected accesses raise pslverr and the counter write leaves the count alone
        add_row(apb_write, 0, 32'h004, 32'h5, 32'h0, 1'b1);
        add_row(apb_read, 0, 32'h004, 32'h0, 32'h3, 1'b0);
        add_row(apb_read, 0, 32'h0FC, 32'h0, 32'h0, 1'b1);
        add_row(apb_read, 0, 32'h114, 32'h0, 32'h0, 1'b1);
        add_row(apb_read, 0, 32'h000, 32'h0, 32'h1, 1'b0);
        add_row(apb_write, 0, 32'h000, 32'h0, 32'h0, 1'b0);
        add_row(apb_read, 0, 32'h000, 32'h0, 32'h0, 1'b0);
        add_row(apb_write, 0, 32'h000, 32'h1, 32'h0, 1'b0);
        add_row(apb_read, 0, 32'h000, 32'h0, 32'h1, 1'b0);
    endtask

    // All four ports run at once and port 3 asks for the invalid page
    task automatic run_all_ports(input logic [11:0] offset);
        fork
            run_translation(0, {6'h10, offset});
            run_translation(1, {6'h11, offset ^ 12'h0F0});
            run_translation(2, {6'h12, offset ^ 12'hF00});
            run_translation(3, {6'h2A, offset});
        join
    endtask

    initial
    begin
        int cycles;
        seed = 54397;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        req_valid = '0;
        rsp_ready = '0;
        for (int p = 0; p < n_ports; p++)
        begin
            req_va[p] = '0;
        end
        for (int v = 0; v < table_size; v++)
        begin
            pt_valid[v] = 1'b0;
            pt_ppn[v] = '0;
        end
        model_enable = 1'b0;
        build_table();

        cycles = 0;
        while (reset !== 1'b0)
        begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit)
            begin
                wait_expired("reset to be released");
            end
        end
        @(negedge clk);

        for (int i = 0; i < n_rows; i++)
        begin
            case (row_kind[i])
                apb_write: write_checked(row_addr[i][11:0], row_data[i], row_err[i]);
                apb_read:  read_checked(row_addr[i][11:0], row_exp[i], row_err[i]);
                default:   run_translation(row_port[i], row_addr[i][va_bits-1:0]);
            endcase
        end

        // Fresh pages for the concurrent phase
        write_checked(12'h140, 32'h0001_0301, 1'b0);
        write_checked(12'h144, 32'h0001_00F2, 1'b0);
        write_checked(12'h148, 32'h0001_02C3, 1'b0);

        // Counts go on from the 3 hits and 6 misses of the table
        // First round misses on every port after the flush
        run_all_ports(12'h3C5);
        read_reg(12'h008, reg_value);
        check_value("miss_count", reg_value, 32'd10);
        read_reg(12'h004, reg_value);
        check_value("hit_count", reg_value, 32'd3);

        // Second round hits on the valid pages, and the fault misses again
        run_all_ports(12'h81E);
        read_reg(12'h004, reg_value);
        check_value("hit_count", reg_value, 32'd6);
        read_reg(12'h008, reg_value);
        check_value("miss_count", reg_value, 32'd11);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
logic/vtp_types_pkg.sv
logic/vtp_csr_pkg.sv
logic/vtp_csr.sv
logic/vtp_l1_tlb.sv
logic/vtp_l2_service.sv
logic/vtp_svc.sv
dv/vtp_clk_gen.sv
dv/vtp_tb.sv

// ==== Bender.yml ====
package:
  name: vtp_svc

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/vtp_types_pkg.sv
      - logic/vtp_csr_pkg.sv
      - logic/vtp_csr.sv
      - logic/vtp_l1_tlb.sv
      - logic/vtp_l2_service.sv
      - logic/vtp_svc.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/vtp_clk_gen.sv
      - dv/vtp_tb.sv
